// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ######################################################################
// core geometry.
// ######################################################################

// integer data and address width.
`define RV_XLEN 32

// rv32e register count.
`define RV_NREG 16

// register index width, log2 of the count.
`define RV_RIDX_W 4

// instruction word width.
`define RV_ILEN 32

`endif

// File: hdl/rv_pkg.sv
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

  // base opcodes handled by the decoder.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // alu functions, the upper six are branch compares.
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // decode to execute.
  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   opj;     // base of the jump target.
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_RIDX_W-1:0] rd;
    alu_op_e               alu_op;
    logic                  wen;
    logic                  jen;     // jal or jalr.
    logic                  ben;     // conditional branch.
    logic                  ebreak;
    logic                  illegal;
  } idu_bundle_t;

  // one retired instruction.
  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_RIDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]   wdata;
    logic                  wen;
    logic                  jump_taken;
    logic [`RV_XLEN-1:0]   target;  // next pc.
    logic                  ebreak;
    logic                  illegal;
  } retire_t;

endpackage

`default_nettype wire

// File: hdl/idu_decoder.sv
`default_nettype none

`include "rv_macros.svh"

module idu_decoder (
  input  wire logic [`RV_ILEN-1:0] inst_i,
  input  wire logic [`RV_XLEN-1:0] pc_i,
  input  wire logic [`RV_XLEN-1:0] rs1v_i,
  input  wire logic [`RV_XLEN-1:0] rs2v_i,
  output rv_pkg::idu_bundle_t      bundle_o,
  output logic                     uses_rs1_o,
  output logic                     uses_rs2_o
);

  rv_pkg::opcode_e       opcode;
  rv_pkg::alu_op_e       alu_op;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_RIDX_W-1:0] rd;
  logic [`RV_XLEN-1:0]   imm_i, imm_u, imm_j, imm_b;
  logic [`RV_XLEN-1:0]   op1, op2, opj, imm;
  logic                  writes, jen, ben, ebreak, illegal, wen;

  assign opcode = rv_pkg::opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd     = inst_i[7 +: `RV_RIDX_W];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    op1        = rs1v_i;
    op2        = rs2v_i;
    opj        = pc_i;
    imm        = '0;
    alu_op     = rv_pkg::ALU_ADD;
    writes     = 1'b0;
    jen        = 1'b0;
    ben        = 1'b0;
    ebreak     = 1'b0;
    illegal    = 1'b0;
    uses_rs1_o = 1'b0;
    uses_rs2_o = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        op1    = '0;
        op2    = imm_u;
        imm    = imm_u;
        writes = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        op1    = pc_i;
        op2    = imm_u;
        imm    = imm_u;
        writes = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        imm    = imm_j;
        writes = 1'b1;
        jen    = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        uses_rs1_o = 1'b1;
        opj        = rs1v_i;
        imm        = imm_i;
        writes     = 1'b1;
        jen        = 1'b1;
        illegal    = funct3 != 3'b000;
      end
      rv_pkg::OPC_BRANCH: begin
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        imm        = imm_b;
        ben        = 1'b1;
        case (funct3)
          3'b000:  alu_op = rv_pkg::ALU_EQ;
          3'b001:  alu_op = rv_pkg::ALU_NE;
          3'b100:  alu_op = rv_pkg::ALU_LT;
          3'b101:  alu_op = rv_pkg::ALU_GE;
          3'b110:  alu_op = rv_pkg::ALU_LTU;
          3'b111:  alu_op = rv_pkg::ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        uses_rs1_o = 1'b1;
        op2        = imm_i;
        imm        = imm_i;
        writes     = 1'b1;
        case (funct3)
          3'b000: alu_op = rv_pkg::ALU_ADD;
          3'b001: begin
            alu_op  = rv_pkg::ALU_SLL;
            illegal = funct7 != 7'b0000000;
          end
          3'b010: alu_op = rv_pkg::ALU_SLT;
          3'b011: alu_op = rv_pkg::ALU_SLTU;
          3'b100: alu_op = rv_pkg::ALU_XOR;
          3'b101: begin
            alu_op  = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            illegal = {funct7[6], funct7[4:0]} != 6'b0;
          end
          3'b110: alu_op = rv_pkg::ALU_OR;
          default: alu_op = rv_pkg::ALU_AND;
        endcase
      end
      rv_pkg::OPC_OP: begin
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        writes     = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  alu_op = rv_pkg::ALU_SLL;
          3'b010:  alu_op = rv_pkg::ALU_SLT;
          3'b011:  alu_op = rv_pkg::ALU_SLTU;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          default: alu_op = rv_pkg::ALU_AND;
        endcase
        // only add and shift right have the alternate form.
        illegal = (funct7 != 7'b0000000) &&
                  !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_pkg::OPC_SYSTEM: begin
        ebreak  = inst_i == 32'h0010_0073;
        illegal = inst_i != 32'h0010_0073;  // ecall and csr ops.
      end
      default: illegal = 1'b1;  // loads, stores and the rest.
    endcase
  end

  // x0 destinations never count as writes.
  assign wen = writes && !illegal && (rd != '0);

  assign bundle_o = '{
    pc:      pc_i,
    op1:     op1,
    op2:     op2,
    opj:     opj,
    imm:     imm,
    rd:      wen ? rd : '0,
    alu_op:  alu_op,
    wen:     wen,
    jen:     jen && !illegal,
    ben:     ben && !illegal,
    ebreak:  ebreak,
    illegal: illegal
  };

endmodule

`default_nettype wire

// File: hdl/idu_stage.sv
`default_nettype none

`include "rv_macros.svh"

module idu_stage (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic [`RV_ILEN-1:0]   inst_i,
  input  wire logic [`RV_XLEN-1:0]   pc_i,
  input  wire logic                  in_valid_i,
  output logic                       in_ready_o,

  output logic [`RV_RIDX_W-1:0]      rs1_o,
  output logic [`RV_RIDX_W-1:0]      rs2_o,
  input  wire logic [`RV_XLEN-1:0]   rdata1_i,
  input  wire logic [`RV_XLEN-1:0]   rdata2_i,
  input  wire logic                  pend1_i,
  input  wire logic                  pend2_i,

  input  wire logic                  fwd_valid_i,
  input  wire logic [`RV_RIDX_W-1:0] fwd_rd_i,
  input  wire logic [`RV_XLEN-1:0]   fwd_data_i,

  output rv_pkg::idu_bundle_t        bundle_o,
  output logic                       valid_o,
  output logic                       issue_o
);

  logic [`RV_ILEN-1:0] inst_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic                valid_q;

  logic                match1, match2;
  logic [`RV_XLEN-1:0] rs1v, rs2v;
  logic                uses_rs1, uses_rs2;
  logic                hazard;

  // ####################################################################
  // instruction register.
  // ####################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;  // empties when nothing is offered.
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // ####################################################################
  // operands and hazard.
  // ####################################################################

  assign rs1_o = inst_q[15 +: `RV_RIDX_W];
  assign rs2_o = inst_q[20 +: `RV_RIDX_W];

  assign match1 = fwd_valid_i && (rs1_o == fwd_rd_i);
  assign match2 = fwd_valid_i && (rs2_o == fwd_rd_i);

  assign rs1v = match1 ? fwd_data_i : rdata1_i;  // execute result wins.
  assign rs2v = match2 ? fwd_data_i : rdata2_i;

  idu_decoder i_decoder (
    .inst_i     (inst_q),
    .pc_i       (pc_q),
    .rs1v_i     (rs1v),
    .rs2v_i     (rs2v),
    .bundle_o   (bundle_o),
    .uses_rs1_o (uses_rs1),
    .uses_rs2_o (uses_rs2)
  );

  // owed by writeback and not covered by the forward.
  assign hazard = valid_q &&
                  ((uses_rs1 && pend1_i && !match1) ||
                   (uses_rs2 && pend2_i && !match2));

  assign in_ready_o = !hazard;
  assign valid_o    = valid_q && !hazard;
  assign issue_o    = valid_o && bundle_o.wen;

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

`include "rv_macros.svh"

module reg_file (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic [`RV_RIDX_W-1:0] rs1_i,
  input  wire logic [`RV_RIDX_W-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]        rdata1_o,
  output logic [`RV_XLEN-1:0]        rdata2_o,
  output logic                       pend1_o,
  output logic                       pend2_o,

  input  wire logic                  set_i,
  input  wire logic [`RV_RIDX_W-1:0] set_rd_i,

  input  wire logic                  wen_i,
  input  wire logic [`RV_RIDX_W-1:0] wrd_i,
  input  wire logic [`RV_XLEN-1:0]   wdata_i
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];
  logic [`RV_NREG-1:0] pend;

  always_ff @(posedge clk) begin
    if (wen_i && wrd_i != '0) begin
      regs[wrd_i] <= wdata_i;
    end
  end

  // a write in flight is passed through, so an older twin of the same rd
  // clearing the table cannot expose a stale value.
  assign rdata1_o = (rs1_i == '0) ? '0 :
                    (wen_i && wrd_i == rs1_i) ? wdata_i : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 :
                    (wen_i && wrd_i == rs2_i) ? wdata_i : regs[rs2_i];

  // ####################################################################
  // scoreboard.
  // ####################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
    end else begin
      for (int i = 0; i < `RV_NREG; i++) begin
        if (set_i && set_rd_i == i) begin
          pend[i] <= 1'b1;  // a new issue beats the clear.
        end else if (wen_i && wrd_i == i) begin
          pend[i] <= 1'b0;
        end
      end
    end
  end

  assign pend1_o = pend[rs1_i];
  assign pend2_o = pend[rs2_i];

endmodule

`default_nettype wire

// File: hdl/exu_stage.sv
`default_nettype none

`include "rv_macros.svh"

module exu_stage (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  rv_pkg::idu_bundle_t        bundle_i,
  input  wire logic                  valid_i,

  output logic                       fwd_valid_o,
  output logic [`RV_RIDX_W-1:0]      fwd_rd_o,
  output logic [`RV_XLEN-1:0]        fwd_data_o,

  output rv_pkg::retire_t            result_o,
  output logic                       result_valid_o
);

  rv_pkg::idu_bundle_t bundle_q;
  logic                valid_q;

  logic [`RV_XLEN-1:0] alu_res;
  logic                cond;
  logic [`RV_XLEN-1:0] link, sum, target, wdata;
  logic                taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    bundle_q <= bundle_i;
  end

  // ####################################################################
  // alu and branch compare.
  // ####################################################################

  always_comb begin
    alu_res = '0;
    cond    = 1'b0;
    case (bundle_q.alu_op)
      rv_pkg::ALU_ADD:  alu_res = bundle_q.op1 + bundle_q.op2;
      rv_pkg::ALU_SUB:  alu_res = bundle_q.op1 - bundle_q.op2;
      rv_pkg::ALU_SLL:  alu_res = bundle_q.op1 << bundle_q.op2[4:0];
      rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(bundle_q.op1) < $signed(bundle_q.op2)};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, bundle_q.op1 < bundle_q.op2};
      rv_pkg::ALU_XOR:  alu_res = bundle_q.op1 ^ bundle_q.op2;
      rv_pkg::ALU_SRL:  alu_res = bundle_q.op1 >> bundle_q.op2[4:0];
      rv_pkg::ALU_SRA:  alu_res = $signed(bundle_q.op1) >>> bundle_q.op2[4:0];
      rv_pkg::ALU_OR:   alu_res = bundle_q.op1 | bundle_q.op2;
      rv_pkg::ALU_AND:  alu_res = bundle_q.op1 & bundle_q.op2;
      rv_pkg::ALU_EQ:   cond = bundle_q.op1 == bundle_q.op2;
      rv_pkg::ALU_NE:   cond = bundle_q.op1 != bundle_q.op2;
      rv_pkg::ALU_LT:   cond = $signed(bundle_q.op1) < $signed(bundle_q.op2);
      rv_pkg::ALU_GE:   cond = $signed(bundle_q.op1) >= $signed(bundle_q.op2);
      rv_pkg::ALU_LTU:  cond = bundle_q.op1 < bundle_q.op2;
      default:          cond = bundle_q.op1 >= bundle_q.op2;
    endcase
  end

  // jalr drops bit 0, the other targets are even anyway.
  assign sum    = bundle_q.opj + bundle_q.imm;
  assign target = {sum[`RV_XLEN-1:1], sum[0] & !bundle_q.jen};
  assign link   = bundle_q.pc + `RV_XLEN'd4;
  assign taken  = bundle_q.jen || (bundle_q.ben && cond);

  assign wdata = !bundle_q.wen ? '0 : bundle_q.jen ? link : alu_res;

  assign fwd_valid_o = valid_q && bundle_q.wen;
  assign fwd_rd_o    = bundle_q.rd;
  assign fwd_data_o  = wdata;

  assign result_o = '{
    pc:         bundle_q.pc,
    rd:         bundle_q.rd,
    wdata:      wdata,
    wen:        bundle_q.wen,
    jump_taken: taken,
    target:     taken ? target : link,
    ebreak:     bundle_q.ebreak,
    illegal:    bundle_q.illegal
  };
  assign result_valid_o = valid_q;

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
`default_nettype none

`include "rv_macros.svh"

module wb_stage (
  input  wire logic             clk,
  input  wire logic             rst,

  input  rv_pkg::retire_t       result_i,
  input  wire logic             valid_i,

  output rv_pkg::retire_t       retire_o,
  output logic                  retire_valid_o,

  output logic                  wen_o,
  output logic [`RV_RIDX_W-1:0] wrd_o,
  output logic [`RV_XLEN-1:0]   wdata_o
);

  rv_pkg::retire_t retire_q;
  logic            valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    retire_q <= result_i;
  end

  assign retire_o       = retire_q;
  assign retire_valid_o = valid_q;

  // register write lands on the edge that ends the retire cycle.
  assign wen_o   = valid_q && retire_q.wen;
  assign wrd_o   = retire_q.rd;
  assign wdata_o = retire_q.wdata;

endmodule

`default_nettype wire

// File: hdl/core_de_top.sv
`default_nettype none

`include "rv_macros.svh"

module core_de_top (
  input  wire logic                clk,
  input  wire logic                rst,

  input  wire logic [`RV_ILEN-1:0] inst_i,
  input  wire logic [`RV_XLEN-1:0] pc_i,
  input  wire logic                in_valid_i,
  output logic                     in_ready_o,

  output rv_pkg::retire_t          retire_o,
  output logic                     retire_valid_o
);

  rv_pkg::idu_bundle_t   idu_bundle;
  logic                  idu_valid, issue;
  logic [`RV_RIDX_W-1:0] rs1, rs2;
  logic [`RV_XLEN-1:0]   rdata1, rdata2;
  logic                  pend1, pend2;
  logic                  fwd_valid;
  logic [`RV_RIDX_W-1:0] fwd_rd;
  logic [`RV_XLEN-1:0]   fwd_data;
  rv_pkg::retire_t       exu_result;
  logic                  exu_valid;
  logic                  wb_wen;
  logic [`RV_RIDX_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_wdata;

  idu_stage i_idu_stage (
    .clk (clk), .rst (rst),
    .inst_i (inst_i), .pc_i (pc_i), .in_valid_i (in_valid_i), .in_ready_o (in_ready_o),
    .rs1_o (rs1), .rs2_o (rs2), .rdata1_i (rdata1), .rdata2_i (rdata2),
    .pend1_i (pend1), .pend2_i (pend2),
    .fwd_valid_i (fwd_valid), .fwd_rd_i (fwd_rd), .fwd_data_i (fwd_data),
    .bundle_o (idu_bundle), .valid_o (idu_valid), .issue_o (issue)
  );

  reg_file i_reg_file (
    .clk (clk), .rst (rst),
    .rs1_i (rs1), .rs2_i (rs2), .rdata1_o (rdata1), .rdata2_o (rdata2),
    .pend1_o (pend1), .pend2_o (pend2),
    .set_i (issue), .set_rd_i (idu_bundle.rd),
    .wen_i (wb_wen), .wrd_i (wb_rd), .wdata_i (wb_wdata)
  );

  exu_stage i_exu_stage (
    .clk (clk), .rst (rst),
    .bundle_i (idu_bundle), .valid_i (idu_valid),
    .fwd_valid_o (fwd_valid), .fwd_rd_o (fwd_rd), .fwd_data_o (fwd_data),
    .result_o (exu_result), .result_valid_o (exu_valid)
  );

  wb_stage i_wb_stage (
    .clk (clk), .rst (rst),
    .result_i (exu_result), .valid_i (exu_valid),
    .retire_o (retire_o), .retire_valid_o (retire_valid_o),
    .wen_o (wb_wen), .wrd_o (wb_rd), .wdata_o (wb_wdata)
  );

endmodule

`default_nettype wire

// File: verification/core_de_assert.sv
`default_nettype none

`include "rv_macros.svh"

module core_de_assert (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic [`RV_ILEN-1:0] inst_i,
  input  wire logic [`RV_XLEN-1:0] pc_i,
  input  wire logic                in_valid_i,
  input  wire logic                in_ready_i,
  input  rv_pkg::retire_t          retire_i,
  input  wire logic                retire_valid_i,
  input  wire logic                issue_i,
  input  wire logic [`RV_NREG-1:0] pend_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned n_issue;
  int unsigned n_write;

  always_ff @(posedge clk) begin
    if (rst) begin
      n_issue <= 0;
      n_write <= 0;
    end else begin
      n_issue <= n_issue + issue_i;
      n_write <= n_write + (retire_valid_i && retire_i.wen);
    end
  end

  // offered word held while decode stalls.
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    in_valid_i && !in_ready_i |=> in_valid_i && $stable(inst_i) && $stable(pc_i))
    else $error("input changed during stall");

  x0_never_pending: assert property (@(posedge clk) disable iff (rst) !pend_i[0])
    else $error("x0 marked pending");

  write_after_issue: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i && retire_i.wen |-> n_issue > n_write)
    else $error("register write retired without an issue");

endmodule

bind core_de_top core_de_assert i_core_de_assert (
  .clk            (clk),
  .rst            (rst),
  .inst_i         (inst_i),
  .pc_i           (pc_i),
  .in_valid_i     (in_valid_i),
  .in_ready_i     (in_ready_o),
  .retire_i       (retire_o),
  .retire_valid_i (retire_valid_o),
  .issue_i        (issue),
  .pend_i         (i_reg_file.pend)
);

`default_nettype wire

// File: verification/core_de_tb.sv
`default_nettype none

`include "rv_macros.svh"

module core_de_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_REC = 24;
  localparam int WORDS = 6;  // inst, pc, rd, wdata, flags, target.
  localparam int LIMIT = 2 * N_REC + 16 + 50;

  logic                clk;
  logic                rst;
  logic [`RV_ILEN-1:0] inst_i;
  logic [`RV_XLEN-1:0] pc_i;
  logic                in_valid_i;
  logic                in_ready_o;
  rv_pkg::retire_t     retire_o;
  logic                retire_valid_o;

  logic [31:0] stim [N_REC*WORDS];
  int          accepted;
  int          retired;
  int          cycles;

  // record index held in each stage, -1 when empty.
  int                  dec_k;
  int                  exe_k;
  int                  wb_k;
  int                  next_k;
  logic [`RV_NREG-1:0] pend_m;

  core_de_top i_core_de_top (
    .clk            (clk),
    .rst            (rst),
    .inst_i         (inst_i),
    .pc_i           (pc_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .retire_o       (retire_o),
    .retire_valid_o (retire_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ######################################################################
  // checks.
  // ######################################################################

  task automatic check_retire(string name, rv_pkg::retire_t exp, rv_pkg::retire_t act);
    if (exp !== act) begin
      $display("** Error %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp !== act) begin
      $display("** Error %s expected %0d actual %0d", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("** Error %s expected %b actual %b", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic rv_pkg::retire_t expected_retire(int k);
    rv_pkg::retire_t r;
    logic [3:0]      flags;
    flags        = stim[k*WORDS+4][3:0];
    r.pc         = stim[k*WORDS+1];
    r.rd         = stim[k*WORDS+2][`RV_RIDX_W-1:0];
    r.wdata      = stim[k*WORDS+3];
    r.wen        = flags[3];
    r.jump_taken = flags[2];
    r.ebreak     = flags[1];
    r.illegal    = flags[0];
    r.target     = stim[k*WORDS+5];
    return r;
  endfunction

  always @(posedge clk) begin
    if (!rst && retire_valid_o) begin
      if (retired < N_REC) begin
        check_retire($sformatf("retire %0d", retired), expected_retire(retired), retire_o);
      end
      retired++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  // ######################################################################
  // decode hazard model.
  // ######################################################################

  function automatic logic writes_reg(int k);
    return stim[k*WORDS+4][3];
  endfunction

  function automatic logic [`RV_RIDX_W-1:0] dest_reg(int k);
    return stim[k*WORDS+2][`RV_RIDX_W-1:0];
  endfunction

  // lui, auipc, jal and system read no register.
  function automatic logic [1:0] sources_used(logic [31:0] inst);
    case (inst[6:0])
      rv_pkg::OPC_JALR, rv_pkg::OPC_OP_IMM: return 2'b01;
      rv_pkg::OPC_BRANCH, rv_pkg::OPC_OP:   return 2'b11;
      default:                              return 2'b00;
    endcase
  endfunction

  // owed by writeback and not the result sitting in execute.
  function automatic logic source_blocked(logic [`RV_RIDX_W-1:0] rs);
    return pend_m[rs] && !(exe_k >= 0 && writes_reg(exe_k) && dest_reg(exe_k) == rs);
  endfunction

  function automatic logic stall_expected();
    logic [31:0] inst;
    logic [1:0]  used;
    if (dec_k < 0) begin
      return 1'b0;
    end
    inst = stim[dec_k*WORDS];
    used = sources_used(inst);
    return (used[0] && source_blocked(inst[15 +: `RV_RIDX_W])) ||
           (used[1] && source_blocked(inst[20 +: `RV_RIDX_W]));
  endfunction

  always @(posedge clk) begin
    logic stall;
    if (rst) begin
      dec_k  = -1;
      exe_k  = -1;
      wb_k   = -1;
      next_k = 0;
      pend_m = '0;
    end else begin
      stall = stall_expected();
      check_ready($sformatf("ready with record %0d in decode", dec_k), !stall, in_ready_o);
      // an issue of the same rd beats the clear.
      if (wb_k >= 0 && writes_reg(wb_k)) begin
        pend_m[dest_reg(wb_k)] = 1'b0;
      end
      if (!stall && dec_k >= 0 && writes_reg(dec_k)) begin
        pend_m[dest_reg(dec_k)] = 1'b1;
      end
      wb_k  = exe_k;
      exe_k = stall ? -1 : dec_k;
      if (!stall) begin
        dec_k  = in_valid_i ? next_k : -1;
        next_k = in_valid_i ? next_k + 1 : next_k;
      end
    end
  end

  // ######################################################################
  // stimulus.
  // ######################################################################

  initial begin
    rst        = 1'b1;
    inst_i     = '0;
    pc_i       = '0;
    in_valid_i = 1'b0;
    accepted   = 0;
    retired    = 0;
    cycles     = 0;
    void'($urandom(79870));
    $readmemh("verification/core_de_stim.txt", stim);
    if ($isunknown(stim[N_REC*WORDS-1])) begin
      $display("stimulus file is short or missing");
      $display(">>> FAIL");
      $fatal(1, "no stimulus");
    end

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    while (accepted < N_REC) begin
      @(posedge clk);
      if (in_valid_i && in_ready_o) begin
        accepted++;
      end
      if (in_valid_i && !in_ready_o) begin
        // stalled, keep offering the same word.
      end else if (accepted < N_REC && $urandom % 4 != 0) begin
        inst_i     <= stim[accepted*WORDS];
        pc_i       <= stim[accepted*WORDS+1];
        in_valid_i <= 1'b1;
      end else begin
        in_valid_i <= 1'b0;  // idle gap.
      end
    end
    @(posedge clk);
    in_valid_i <= 1'b0;

    wait (retired >= N_REC);
    repeat (5) @(posedge clk);
    check_count("retire count", accepted, retired);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/core_de_stim.txt
// inst     pc       rd       wdata    flags    target
// flags nibble is {wen, jump_taken, ebreak, illegal}
00500093 00000000 00000001 00000005 00000008 00000004 // addi x1, x0, 5
00308113 00000004 00000002 00000008 00000008 00000008 // addi x2, x1, 3
123451b7 00000008 00000003 12345000 00000008 0000000c // lui x3, 0x12345
00218233 0000000c 00000004 12345008 00000008 00000010 // add x4, x3, x2
401202b3 00000010 00000005 12345003 00000008 00000014 // sub x5, x4, x1
00001317 00000014 00000006 00001014 00000008 00000018 // auipc x6, 1
fff0c393 00000018 00000007 fffffffa 00000008 0000001c // xori x7, x1, -1
4043d413 0000001c 00000008 ffffffff 00000008 00000020 // srai x8, x7, 4
0070b4b3 00000020 00000009 00000001 00000008 00000024 // sltu x9, x1, x7
00708013 00000024 00000000 00000000 00000000 00000028 // addi x0, x1, 7
00100533 00000028 0000000a 00000005 00000008 0000002c // add x10, x0, x1
010005ef 0000002c 0000000b 00000030 0000000c 0000003c // jal x11, 16
00558667 00000030 0000000c 00000034 0000000c 00000034 // jalr x12, 5(x11)
00a08463 00000034 00000000 00000000 00000004 0000003c // beq x1, x10, 8
00a09463 00000038 00000000 00000000 00000000 0000003c // bne x1, x10, 8
fe13cee3 0000003c 00000000 00000000 00000004 00000038 // blt x7, x1, -4
0013d463 00000040 00000000 00000000 00000000 00000044 // bge x7, x1, 8
0070e663 00000044 00000000 00000000 00000004 00000050 // bltu x1, x7, 12
0070f663 00000048 00000000 00000000 00000000 0000004c // bgeu x1, x7, 12
00100073 0000004c 00000000 00000000 00000002 00000050 // ebreak
0000a683 00000050 00000000 00000000 00000001 00000054 // lw x13, 0(x1)
002096b3 00000054 0000000d 00000500 00000008 00000058 // sll x13, x1, x2
0056e733 00000058 0000000e 12345503 00000008 0000005c // or x14, x13, x5
0013a7b3 0000005c 0000000f 00000001 00000008 00000060 // slt x15, x7, x1

// File: core_de.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/idu_decoder.sv
hdl/idu_stage.sv
hdl/reg_file.sv
hdl/exu_stage.sv
hdl/wb_stage.sv
hdl/core_de_top.sv
verification/core_de_assert.sv
verification/core_de_tb.sv
